// ==== rtl/mshr_pkg.sv ====
package mshr_pkg;

    // ================================================
    // Sizes
    // ================================================

    // Number of miss status holding registers
    localparam int MSHR_ENTRY_NUM = 4;
    // Entry index width
    localparam int MSHR_IDX_W     = $clog2(MSHR_ENTRY_NUM);
    // Line address width
    localparam int ADDR_W         = 16;
    // Line data width
    localparam int DATA_W         = 32;

    // ================================================
    // Types
    // ================================================

    // Entry index into the MSHR array
    typedef logic [MSHR_IDX_W-1:0] mshr_idx_t;

    // Memory id, entry index plus one
    // Zero is reserved and means no id
    typedef logic [MSHR_IDX_W:0]   mem_id_t;

    // Miss line address and returned line
    typedef logic [ADDR_W-1:0]     line_addr_t;
    typedef logic [DATA_W-1:0]     line_data_t;

    // Entry life cycle
    typedef enum logic [1:0] {
        // Free for allocation
        ENTRY_IDLE,
        // Read issued, line not back yet
        ENTRY_WAIT_MEM,
        // Line held, waiting for the processor port
        ENTRY_HAVE_DATA
    } entry_state_e;

    // Item kind on the shared processor port
    typedef enum logic {
        KIND_TAG  = 1'b0,
        KIND_DATA = 1'b1
    } proc_kind_e;

endpackage

// ==== rtl/mshr_alloc.sv ====
module mshr_alloc import mshr_pkg::*; (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Miss from the processor
    input  logic                      miss_valid_i,
    input  line_addr_t                miss_addr_i,
    // Idle flags from the entry array
    input  logic [MSHR_ENTRY_NUM-1:0] entry_idle_i,
    output logic                      miss_ready_o,
    // Allocation strobe and address to the entries
    output logic [MSHR_ENTRY_NUM-1:0] alloc_onehot_o,
    output line_addr_t                alloc_addr_o,
    // Registered memory read request
    output logic                      mem_req_valid_o,
    output mem_id_t                   mem_req_id_o,
    output line_addr_t                mem_req_addr_o
);

    logic      accept;
    mshr_idx_t free_idx;

    // ================================================
    // Free entry search
    // ================================================

    // Lowest idle entry wins
    // Scan downwards so the last hit is the lowest index
    always_comb begin
        free_idx = '0;
        for (int i = MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (entry_idle_i[i]) begin
                free_idx = mshr_idx_t'(i);
            end
        end
    end

    // Ready while any entry is free
    assign miss_ready_o = |entry_idle_i;
    assign accept       = miss_valid_i & miss_ready_o;

    // One-hot strobe, only in the accepting cycle
    always_comb begin
        alloc_onehot_o = '0;
        if (accept) begin
            alloc_onehot_o[free_idx] = 1'b1;
        end
    end

    // Address goes straight through to the chosen entry
    assign alloc_addr_o = miss_addr_i;

    // ================================================
    // Memory read request
    // ================================================

    // Valid strobe, one cycle after acceptance
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_req_valid_o <= 1'b0;
        end else begin
            mem_req_valid_o <= accept;
        end
    end

    // Request payload, id is index plus one
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_req_id_o   <= {1'b0, free_idx} + 1'b1;
            mem_req_addr_o <= miss_addr_i;
        end
    end

endmodule

// ==== rtl/mshr_entry.sv ====
module mshr_entry import mshr_pkg::*; #(
    parameter int ENTRY_IDX = 0
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Allocation from mshr_alloc
    input  logic       alloc_i,
    input  line_addr_t alloc_addr_i,
    // Shared memory response bus
    input  mem_id_t    mem_resp_id_i,
    input  line_data_t mem_resp_data_i,
    // Grant from the processor port switch
    input  logic       grant_i,
    output logic       idle_o,
    output logic       tag_req_o,
    output logic       data_req_o,
    output line_addr_t addr_o,
    output line_data_t data_o
);

    entry_state_e state_q;
    logic         tag_pend_q;
    logic         resp_hit;
    mem_id_t      own_id;
    line_addr_t   addr_q;
    line_data_t   data_q;

    // Own memory id, never zero
    assign own_id   = mem_id_t'(ENTRY_IDX + 1);
    // Zero id on the bus matches no entry
    assign resp_hit = (mem_resp_id_i == own_id);

    // ================================================
    // Entry FSM
    // ================================================

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ENTRY_IDLE;
            tag_pend_q <= 1'b0;
        end else begin
            case (state_q)
                ENTRY_IDLE: begin
                    // New miss, tag announcement owed
                    if (alloc_i) begin
                        state_q    <= ENTRY_WAIT_MEM;
                        tag_pend_q <= 1'b1;
                    end
                end
                ENTRY_WAIT_MEM: begin
                    // Data arrival drops any unsent announcement
                    if (resp_hit) begin
                        state_q    <= ENTRY_HAVE_DATA;
                        tag_pend_q <= 1'b0;
                    end else if (grant_i) begin
                        // Tag announced
                        tag_pend_q <= 1'b0;
                    end
                end
                ENTRY_HAVE_DATA: begin
                    // Data response sent, entry free again
                    if (grant_i) begin
                        state_q <= ENTRY_IDLE;
                    end
                end
                default: begin
                    state_q <= ENTRY_IDLE;
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (alloc_i && state_q == ENTRY_IDLE) begin
            addr_q <= alloc_addr_i;
        end
        if (resp_hit && state_q == ENTRY_WAIT_MEM) begin
            data_q <= mem_resp_data_i;
        end
    end

    // Request levels toward the switch
    assign idle_o     = (state_q == ENTRY_IDLE);
    assign tag_req_o  = (state_q == ENTRY_WAIT_MEM) && tag_pend_q;
    assign data_req_o = (state_q == ENTRY_HAVE_DATA);
    assign addr_o     = addr_q;
    assign data_o     = data_q;

endmodule

// ==== rtl/mshr_rr_arbiter.sv ====
module mshr_rr_arbiter import mshr_pkg::*; (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // One request bit per entry
    input  logic [MSHR_ENTRY_NUM-1:0] req_i,
    // Grant taken, move the pointer
    input  logic                      ack_i,
    output mshr_idx_t                 grant_o,
    output logic                      valid_o
);

    // Highest priority index
    mshr_idx_t ptr_q;

    // ================================================
    // Grant search
    // ================================================

    // First requester at or after the pointer, wrapping
    // Scan offsets downwards so the smallest offset wins
    always_comb begin
        int unsigned cand;
        grant_o = '0;
        valid_o = 1'b0;
        for (int off = MSHR_ENTRY_NUM - 1; off >= 0; off--) begin
            cand = (int'(ptr_q) + off) % MSHR_ENTRY_NUM;
            if (req_i[cand]) begin
                grant_o = mshr_idx_t'(cand);
                valid_o = 1'b1;
            end
        end
    end

    // ================================================
    // Pointer update
    // ================================================

    // One past the winner, wrap at the last entry
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (ack_i && valid_o) begin
            if (grant_o == mshr_idx_t'(MSHR_ENTRY_NUM - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= grant_o + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mshr_proc_switch.sv ====
module mshr_proc_switch import mshr_pkg::*; (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    // Request levels from each entry
    input  logic       [MSHR_ENTRY_NUM-1:0]       tag_req_i,
    input  logic       [MSHR_ENTRY_NUM-1:0]       data_req_i,
    input  line_addr_t [MSHR_ENTRY_NUM-1:0]       entry_addr_i,
    input  line_data_t [MSHR_ENTRY_NUM-1:0]       entry_data_i,
    // One-hot grant back to the entries
    output logic       [MSHR_ENTRY_NUM-1:0]       proc_grant_o,
    // Shared processor port
    output logic                                  proc_valid_o,
    output proc_kind_e                            proc_kind_o,
    output mem_id_t                               proc_id_o,
    output line_addr_t                            proc_addr_o,
    output line_data_t                            proc_data_o
);

    logic [MSHR_ENTRY_NUM-1:0] arb_req;
    logic                      data_class;
    mshr_idx_t                 grant_idx;
    logic                      grant_valid;

    // Data responses go before tag announcements
    assign data_class = |data_req_i;
    assign arb_req    = data_class ? data_req_i : tag_req_i;

    // Pointer shared by both classes, moves on every grant
    mshr_rr_arbiter u_arbiter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (arb_req),
        .ack_i    (grant_valid),
        .grant_o  (grant_idx),
        .valid_o  (grant_valid)
    );

    // ================================================
    // Port routing
    // ================================================

    // Port is quiet and zero when nobody asks
    always_comb begin
        proc_grant_o = '0;
        proc_valid_o = grant_valid;
        proc_kind_o  = KIND_TAG;
        proc_id_o    = '0;
        proc_addr_o  = '0;
        proc_data_o  = '0;
        if (grant_valid) begin
            proc_grant_o[grant_idx] = 1'b1;
            proc_kind_o = data_class ? KIND_DATA : KIND_TAG;
            // Memory id is index plus one
            proc_id_o   = {1'b0, grant_idx} + 1'b1;
            proc_addr_o = entry_addr_i[grant_idx];
            proc_data_o = entry_data_i[grant_idx];
        end
    end

endmodule

// ==== rtl/mshr_top.sv ====
module mshr_top import mshr_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Processor miss side
    input  logic       miss_valid_i,
    input  line_addr_t miss_addr_i,
    output logic       miss_ready_o,
    // Memory request side
    output logic       mem_req_valid_o,
    output mem_id_t    mem_req_id_o,
    output line_addr_t mem_req_addr_o,
    // Memory response side, nonzero id is a strobe
    input  mem_id_t    mem_resp_id_i,
    input  line_data_t mem_resp_data_i,
    // Processor port, no back-pressure
    output logic       proc_valid_o,
    output proc_kind_e proc_kind_o,
    output mem_id_t    proc_id_o,
    output line_addr_t proc_addr_o,
    output line_data_t proc_data_o
);

    logic       [MSHR_ENTRY_NUM-1:0] entry_idle;
    logic       [MSHR_ENTRY_NUM-1:0] alloc_onehot;
    line_addr_t                      alloc_addr;
    logic       [MSHR_ENTRY_NUM-1:0] tag_req;
    logic       [MSHR_ENTRY_NUM-1:0] data_req;
    line_addr_t [MSHR_ENTRY_NUM-1:0] entry_addr;
    line_data_t [MSHR_ENTRY_NUM-1:0] entry_data;
    logic       [MSHR_ENTRY_NUM-1:0] proc_grant;

    // Miss decode and memory request
    mshr_alloc u_alloc (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .miss_valid_i    (miss_valid_i),
        .miss_addr_i     (miss_addr_i),
        .entry_idle_i    (entry_idle),
        .miss_ready_o    (miss_ready_o),
        .alloc_onehot_o  (alloc_onehot),
        .alloc_addr_o    (alloc_addr),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_id_o    (mem_req_id_o),
        .mem_req_addr_o  (mem_req_addr_o)
    );

    // Entry array, response bus fanned out to all
    for (genvar i = 0; i < MSHR_ENTRY_NUM; i++) begin : g_entry
        mshr_entry #(
            .ENTRY_IDX (i)
        ) u_entry (
            .clk_i           (clk_i),
            .arst_n_i        (arst_n_i),
            .alloc_i         (alloc_onehot[i]),
            .alloc_addr_i    (alloc_addr),
            .mem_resp_id_i   (mem_resp_id_i),
            .mem_resp_data_i (mem_resp_data_i),
            .grant_i         (proc_grant[i]),
            .idle_o          (entry_idle[i]),
            .tag_req_o       (tag_req[i]),
            .data_req_o      (data_req[i]),
            .addr_o          (entry_addr[i]),
            .data_o          (entry_data[i])
        );
    end

    // Processor port scheduling
    mshr_proc_switch u_switch (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .tag_req_i    (tag_req),
        .data_req_i   (data_req),
        .entry_addr_i (entry_addr),
        .entry_data_i (entry_data),
        .proc_grant_o (proc_grant),
        .proc_valid_o (proc_valid_o),
        .proc_kind_o  (proc_kind_o),
        .proc_id_o    (proc_id_o),
        .proc_addr_o  (proc_addr_o),
        .proc_data_o  (proc_data_o)
    );

endmodule

// ==== testbench/mshr_sva.sv ====
module mshr_sva import mshr_pkg::*; (
    input logic                      clk_i,
    input logic                      arst_n_i,
    input logic [MSHR_ENTRY_NUM-1:0] data_req_i,
    input logic [MSHR_ENTRY_NUM-1:0] proc_grant_o,
    input logic                      proc_valid_o,
    input proc_kind_e                proc_kind_o
);

    // Failed assertion count
    int fail_count = 0;

    // At most one entry granted
    a_grant_onehot0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(proc_grant_o))
        else begin
            $error("switch grant is not one-hot or zero");
            fail_count++;
        end

    // Port valid exactly when someone is granted
    a_valid_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        proc_valid_o == (|proc_grant_o))
        else begin
            $error("proc_valid_o disagrees with the grant");
            fail_count++;
        end

    // Data responses go before tag announcements
    a_data_first: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (|data_req_i) |-> !(proc_valid_o && proc_kind_o == KIND_TAG))
        else begin
            $error("tag announced while a data response waits");
            fail_count++;
        end

endmodule

bind mshr_proc_switch mshr_sva u_sva (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .data_req_i   (data_req_i),
    .proc_grant_o (proc_grant_o),
    .proc_valid_o (proc_valid_o),
    .proc_kind_o  (proc_kind_o)
);

// ==== testbench/mshr_tb.sv ====
module mshr_tb import mshr_pkg::*;;

    localparam int CLK_PERIOD  = 100;
    localparam int STIM_CYCLES = 2000;
    localparam int DRAIN_MAX   = 200;

    logic       clk;
    logic       arst_n;
    logic       miss_valid;
    line_addr_t miss_addr;
    mem_id_t    resp_id;
    line_data_t resp_data;
    logic       miss_ready;
    logic       mem_req_valid;
    logic       proc_valid;
    mem_id_t    mem_req_id;
    mem_id_t    proc_id;
    line_addr_t mem_req_addr;
    line_addr_t proc_addr;
    line_data_t proc_data;
    proc_kind_e proc_kind;

    // Reference model with one slot per entry index
    entry_state_e m_state [MSHR_ENTRY_NUM];
    logic         m_tag_pend [MSHR_ENTRY_NUM];
    line_addr_t   m_addr [MSHR_ENTRY_NUM];
    line_data_t   m_data [MSHR_ENTRY_NUM];
    // Model copy of the round-robin pointer
    int           m_ptr;
    // Memory request owed from last cycle's acceptance
    logic         exp_req_valid;
    int           exp_req_id;
    line_addr_t   exp_req_addr;

    logic [15:0]  lfsr_q = 16'd31;
    int           checks = 0;
    int           errors = 0;
    int           accepted = 0;
    int           data_seen = 0;

    mshr_top dut_i (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .miss_valid_i    (miss_valid),
        .miss_addr_i     (miss_addr),
        .miss_ready_o    (miss_ready),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_id_o    (mem_req_id),
        .mem_req_addr_o  (mem_req_addr),
        .mem_resp_id_i   (resp_id),
        .mem_resp_data_i (resp_data),
        .proc_valid_o    (proc_valid),
        .proc_kind_o     (proc_kind),
        .proc_id_o       (proc_id),
        .proc_addr_o     (proc_addr),
        .proc_data_o     (proc_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ================================================
    // Helpers
    // ================================================

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    // Compare one value and count the check
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
        end
    endtask

    // Any entry still in use in the model
    function automatic bit entries_busy();
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            if (m_state[i] != ENTRY_IDLE) return 1'b1;
        end
        return 1'b0;
    endfunction

    // ================================================
    // One clock cycle of stimulus, check and model update
    // ================================================

    task automatic run_cycle(input bit stim_on);
        int                        gnt;
        int                        free_idx;
        int                        ridx;
        int                        start;
        int                        idx;
        logic                      idle_any;
        logic                      use_data;
        logic [MSHR_ENTRY_NUM-1:0] dmask;
        logic [MSHR_ENTRY_NUM-1:0] tmask;
        logic [MSHR_ENTRY_NUM-1:0] mask;
        @(posedge clk);
        // Miss with probability one half
        miss_valid <= stim_on ? 1'(rand_bits(1)) : 1'b0;
        miss_addr  <= line_addr_t'(rand_bits(ADDR_W));
        // Return one waiting id at random or always while draining
        ridx = -1;
        if (!stim_on || rand_bits(1) == 32'd1) begin
            start = int'(rand_bits(MSHR_IDX_W));
            for (int off = 0; off < MSHR_ENTRY_NUM; off++) begin
                idx = (start + off) % MSHR_ENTRY_NUM;
                if (ridx < 0 && m_state[idx] == ENTRY_WAIT_MEM) ridx = idx;
            end
        end
        resp_id   <= (ridx < 0) ? mem_id_t'(0) : mem_id_t'(ridx + 1);
        resp_data <= line_data_t'(rand_bits(DATA_W));

        // Outputs are settled by the falling edge
        @(negedge clk);
        // Lowest free entry and the two request classes
        idle_any = 1'b0;
        free_idx = -1;
        for (int i = MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (m_state[i] == ENTRY_IDLE) begin
                idle_any = 1'b1;
                free_idx = i;
            end
            dmask[i] = (m_state[i] == ENTRY_HAVE_DATA);
            tmask[i] = (m_state[i] == ENTRY_WAIT_MEM) && m_tag_pend[i];
        end
        // Data class first and then the first requester at or after the pointer
        use_data = |dmask;
        mask     = use_data ? dmask : tmask;
        gnt      = -1;
        for (int off = 0; off < MSHR_ENTRY_NUM; off++) begin
            idx = (m_ptr + off) % MSHR_ENTRY_NUM;
            if (gnt < 0 && mask[idx]) gnt = idx;
        end

        check_value("miss_ready_o", miss_ready, idle_any);
        check_value("mem_req_valid_o", mem_req_valid, exp_req_valid);
        if (exp_req_valid) begin
            check_value("mem_req_id_o", mem_req_id, exp_req_id);
            check_value("mem_req_addr_o", mem_req_addr, exp_req_addr);
        end
        check_value("proc_valid_o", proc_valid, gnt >= 0);
        if (proc_valid && proc_kind == KIND_DATA) data_seen++;
        if (gnt >= 0) begin
            check_value("proc_kind_o", proc_kind, use_data ? KIND_DATA : KIND_TAG);
            check_value("proc_id_o", proc_id, gnt + 1);
            check_value("proc_addr_o", proc_addr, m_addr[gnt]);
            // Data response frees the id
            if (use_data) begin
                check_value("proc_data_o", proc_data, m_data[gnt]);
                m_state[gnt] = ENTRY_IDLE;
            end else begin
                m_tag_pend[gnt] = 1'b0;
            end
            m_ptr = (gnt + 1) % MSHR_ENTRY_NUM;
        end

        // Response lands at the next edge and drops any pending tag
        if (resp_id != '0) begin
            idx             = int'(resp_id) - 1;
            m_state[idx]    = ENTRY_HAVE_DATA;
            m_tag_pend[idx] = 1'b0;
            m_data[idx]     = resp_data;
        end
        // Allocation goes to the lowest entry idle in this cycle
        exp_req_valid = miss_valid && idle_any;
        if (exp_req_valid) begin
            m_state[free_idx]    = ENTRY_WAIT_MEM;
            m_tag_pend[free_idx] = 1'b1;
            m_addr[free_idx]     = miss_addr;
            exp_req_id           = free_idx + 1;
            exp_req_addr         = miss_addr;
            accepted++;
        end
    endtask

    // ================================================
    // Main sequence
    // ================================================

    initial begin
        int c0;
        int e0;
        arst_n     = 1'b0;
        miss_valid = 1'b0;
        miss_addr  = '0;
        resp_id    = '0;
        resp_data  = '0;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            m_state[i]    = ENTRY_IDLE;
            m_tag_pend[i] = 1'b0;
            m_addr[i]     = '0;
            m_data[i]     = '0;
        end
        m_ptr         = 0;
        exp_req_valid = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        // Idle state right after reset
        c0 = checks;
        e0 = errors;
        check_value("miss_ready_o", miss_ready, 1'b1);
        check_value("mem_req_valid_o", mem_req_valid, 1'b0);
        check_value("proc_valid_o", proc_valid, 1'b0);
        $display("test reset: %0d checks, %0d errors", checks - c0, errors - e0);

        c0 = checks;
        e0 = errors;
        for (int n = 0; n < STIM_CYCLES; n++) run_cycle(1'b1);
        $display("test random_traffic: %0d checks, %0d errors", checks - c0, errors - e0);

        // Return every outstanding id and empty the port
        c0 = checks;
        e0 = errors;
        for (int n = 0; n < DRAIN_MAX && entries_busy(); n++) run_cycle(1'b0);
        run_cycle(1'b0);
        if (entries_busy()) begin
            errors++;
            $display("drain left entries busy after %0d cycles", DRAIN_MAX);
        end
        check_value("miss_ready_o", miss_ready, 1'b1);
        // One data response per accepted miss
        check_value("data_responses", data_seen, accepted);
        $display("test drain: %0d checks, %0d errors", checks - c0, errors - e0);

        if (dut_i.u_switch.u_sva.fail_count != 0) begin
            errors += dut_i.u_switch.u_sva.fail_count;
            $display("switch assertions failed %0d times", dut_i.u_switch.u_sva.fail_count);
        end

        $display("total: %0d checks, %0d errors, %0d misses", checks, errors, accepted);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        #(STIM_CYCLES * CLK_PERIOD * 4);
        $display("watchdog expired before the run finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
rtl/mshr_pkg.sv
rtl/mshr_alloc.sv
rtl/mshr_entry.sv
rtl/mshr_rr_arbiter.sv
rtl/mshr_proc_switch.sv
rtl/mshr_top.sv
testbench/mshr_sva.sv
testbench/mshr_tb.sv

// ==== Makefile ====
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mshr_tb \
		-Mdir $(OBJ_DIR) -f build.f
	@out="$$(./$(OBJ_DIR)/Vmshr_tb)"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
